// ==== compile.f ====
logic/prf_pkg.sv
logic/rotating_pick.sv
logic/bank_ram.sv
logic/wb_arbiter.sv
logic/read_arbiter.sv
logic/prf_top.sv
sim/prf_tb.sv

// ==== sim/prf_tb.sv ====
// register file testbench
`default_nettype none

module prf_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import prf_pkg::*;

    localparam int RR_COUNT = 6;
    localparam int WR_COUNT = 3;
    localparam int RESET_CYCLES = 10;
    localparam int STEP_COUNT = 12;
    localparam int CYCLE_LIMIT = STEP_COUNT * 40 + RESET_CYCLES;

    // one table row
    // writers use the low entries of prs and act
    typedef struct packed {
        logic                   is_read;
        logic [RR_COUNT-1:0]    act;
        pr_t [RR_COUNT-1:0]     prs;
    } step_t;

    logic                           CLK;
    logic                           nRST;
    logic [WR_COUNT-1:0]            wb_valid;
    wb_req_t [WR_COUNT-1:0]         wb_req;
    logic [WR_COUNT-1:0]            wb_ready;
    wb_bus_t [BANK_COUNT-1:0]       wb_bus;
    logic [RR_COUNT-1:0]            rd_req_valid;
    pr_t [RR_COUNT-1:0]             rd_req_pr;
    logic [RR_COUNT-1:0]            rd_ack;
    rd_port_e [RR_COUNT-1:0]        rd_port;
    data_t [BANK_COUNT-1:0][1:0]    rd_data;

    step_t      steps [STEP_COUNT];
    data_t      shadow [PR_COUNT];
    rob_index_t rob_tag;
    int         cycle_count;

    prf_top #(
        .RR_COUNT (RR_COUNT),
        .WR_COUNT (WR_COUNT)
    ) u_prf_top (
        .CLK          (CLK),
        .nRST         (nRST),
        .wb_valid     (wb_valid),
        .wb_req       (wb_req),
        .wb_ready     (wb_ready),
        .wb_bus       (wb_bus),
        .rd_req_valid (rd_req_valid),
        .rd_req_pr    (rd_req_pr),
        .rd_ack       (rd_ack),
        .rd_port      (rd_port),
        .rd_data      (rd_data)
    );

    always #20 CLK = ~CLK;

    // run limit
    always @(posedge CLK) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: the test did not finish within %0d cycles", CYCLE_LIMIT);
            abort_run();
        end
    end

    // ------------------------------
    // reporting and compare tasks

    task automatic abort_run();
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic report_mismatch(input string msg);
        $display("CHECK FAILED at %0t: %s", $time, msg);
        abort_run();
    endtask

    task automatic check_data(input data_t act, input data_t exp, input string msg);
        if (act !== exp) begin
            report_mismatch($sformatf("%s: data %h, expected %h", msg, act, exp));
        end
    endtask

    task automatic check_bus(input wb_bus_t act, input wb_bus_t exp, input string msg);
        if (act !== exp) begin
            report_mismatch($sformatf("%s: bus v%b d%h r%0d t%0d, expected v%b d%h r%0d t%0d",
                msg, act.valid, act.data, act.upper_pr, act.rob_index,
                exp.valid, exp.data, exp.upper_pr, exp.rob_index));
        end
    endtask

    task automatic check_ready(input logic [WR_COUNT-1:0] act, input logic [WR_COUNT-1:0] exp,
                               input logic [WR_COUNT-1:0] care, input string msg);
        if ((act & care) !== (exp & care)) begin
            report_mismatch($sformatf("%s: wb_ready %b, expected %b", msg, act, exp));
        end
    endtask

    function automatic step_t make_step(input logic is_read, input logic [RR_COUNT-1:0] act,
                                        input int p0, input int p1, input int p2,
                                        input int p3, input int p4, input int p5);
        step_t s;
        s.is_read = is_read;
        s.act = act;
        s.prs[0] = pr_t'(p0);
        s.prs[1] = pr_t'(p1);
        s.prs[2] = pr_t'(p2);
        s.prs[3] = pr_t'(p3);
        s.prs[4] = pr_t'(p4);
        s.prs[5] = pr_t'(p5);
        return s;
    endfunction

    // ------------------------------
    // write burst

    task automatic run_write(input step_t s);
        wb_req_t             req [WR_COUNT];
        logic [WR_COUNT-1:0] outstanding;
        logic [WR_COUNT-1:0] care;
        wb_bus_t             exp;
        int                  cycle;
        bit                  found;
        bit                  done;
        care = '1;
        outstanding = '0;
        @(posedge CLK);
        for (int w = 0; w < WR_COUNT; w++) begin
            req[w].data = $urandom;
            req[w].pr = s.prs[w];
            req[w].rob_index = rob_tag;
            rob_tag++;
            wb_req[w] <= req[w];
        end
        wb_valid <= s.act[WR_COUNT-1:0];
        // all slots are empty here, so every request is taken at this edge
        @(posedge CLK);
        wb_valid <= '0;
        for (int w = 0; w < WR_COUNT; w++) begin
            if (s.act[w] && req[w].pr == '0) begin
                care[w] = 1'b0;
            end else begin
                outstanding[w] = s.act[w];
            end
        end
        cycle = 0;
        done = 0;
        while (!done) begin
            @(negedge CLK);
            cycle++;
            for (int b = 0; b < BANK_COUNT; b++) begin
                if (wb_bus[b].valid === 1'b1) begin
                    found = 0;
                    for (int w = 0; w < WR_COUNT; w++) begin
                        if (outstanding[w] && req[w].rob_index == wb_bus[b].rob_index
                                && req[w].pr[LOG_BANK_COUNT-1:0] == b) begin
                            exp.valid = 1'b1;
                            exp.data = req[w].data;
                            exp.upper_pr = req[w].pr[LOG_PR_COUNT-1:LOG_BANK_COUNT];
                            exp.rob_index = req[w].rob_index;
                            check_bus(wb_bus[b], exp, $sformatf("writer %0d bank %0d", w, b));
                            shadow[req[w].pr] = req[w].data;
                            outstanding[w] = 1'b0;
                            found = 1;
                            if ($countones(s.act[WR_COUNT-1:0]) == 1 && cycle != 1) begin
                                report_mismatch("lone write did not appear in the next cycle");
                            end
                        end
                    end
                    if (!found) begin
                        report_mismatch($sformatf("unexpected bus entry on bank %0d", b));
                    end
                end
            end
            check_ready(wb_ready, ~outstanding, care, "during write burst");
            done = (outstanding == '0) && (wb_ready === '1);
        end

        // no write may show up a second time
        @(negedge CLK);
        for (int b = 0; b < BANK_COUNT; b++) begin
            if (wb_bus[b].valid !== 1'b0) begin
                report_mismatch($sformatf("bus entry on bank %0d after the burst", b));
            end
        end
    endtask

    // ------------------------------
    // read burst

    task automatic run_read(input step_t s);
        logic [RR_COUNT-1:0] waiting;
        logic [1:0]          port_used [BANK_COUNT];
        int                  bank;
        int                  port;
        @(posedge CLK);
        rd_req_valid <= s.act;
        rd_req_pr <= s.prs;
        @(posedge CLK);
        rd_req_valid <= '0;
        waiting = s.act;
        while (waiting != '0) begin
            @(negedge CLK);
            for (int b = 0; b < BANK_COUNT; b++) begin
                port_used[b] = '0;
            end
            for (int r = 0; r < RR_COUNT; r++) begin
                if (rd_ack[r] === 1'b1) begin
                    if (!waiting[r]) begin
                        report_mismatch($sformatf("requester %0d acked without a request", r));
                    end
                    bank = s.prs[r][LOG_BANK_COUNT-1:0];
                    port = int'(rd_port[r]);
                    if (port_used[bank][port]) begin
                        report_mismatch($sformatf("bank %0d port %0d acked twice", bank, port));
                    end
                    port_used[bank][port] = 1'b1;
                    check_data(rd_data[bank][port], shadow[s.prs[r]],
                        $sformatf("requester %0d pr %0d", r, s.prs[r]));
                    waiting[r] = 1'b0;
                end
            end
        end

        // one ack per request and no more
        @(negedge CLK);
        if (rd_ack !== '0) begin
            report_mismatch($sformatf("rd_ack %b after every request was served", rd_ack));
        end
    endtask

    // ------------------------------
    // main sequence

    initial begin
        void'($urandom(32'hc98bde0c));
        CLK = 1'b0;
        nRST = 1'b0;
        wb_valid = '0;
        wb_req = '0;
        rd_req_valid = '0;
        rd_req_pr = '0;
        rob_tag = '0;
        cycle_count = 0;

        // bank is pr[1:0], row is pr[5:2]
        steps[0] = make_step(1'b0, 6'b000001, 5, 0, 0, 0, 0, 0);
        steps[1] = make_step(1'b1, 6'b000001, 5, 0, 0, 0, 0, 0);
        steps[2] = make_step(1'b0, 6'b000111, 6, 10, 14, 0, 0, 0);
        steps[3] = make_step(1'b0, 6'b000111, 0, 4, 8, 0, 0, 0);
        steps[4] = make_step(1'b0, 6'b000111, 18, 22, 26, 0, 0, 0);
        steps[5] = make_step(1'b1, 6'b111111, 6, 10, 14, 18, 22, 26);
        steps[6] = make_step(1'b0, 6'b000111, 7, 13, 11, 0, 0, 0);
        steps[7] = make_step(1'b1, 6'b111111, 5, 4, 6, 7, 13, 11);
        steps[8] = make_step(1'b0, 6'b000111, 15, 17, 20, 0, 0, 0);
        steps[9] = make_step(1'b1, 6'b111111, 15, 17, 20, 8, 10, 14);
        steps[10] = make_step(1'b0, 6'b000111, 6, 5, 3, 0, 0, 0);
        steps[11] = make_step(1'b1, 6'b111111, 6, 5, 3, 26, 4, 7);

        repeat (RESET_CYCLES) @(posedge CLK);
        nRST <= 1'b1;
        @(negedge CLK);
        check_ready(wb_ready, '1, '1, "after reset");
        if (rd_ack !== '0) begin
            report_mismatch("rd_ack high after reset");
        end
        for (int b = 0; b < BANK_COUNT; b++) begin
            if (wb_bus[b].valid !== 1'b0) begin
                report_mismatch($sformatf("bus valid on bank %0d after reset", b));
            end
        end

        for (int i = 0; i < STEP_COUNT; i++) begin
            if (steps[i].is_read) begin
                run_read(steps[i]);
            end else begin
                run_write(steps[i]);
            end
        end

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== logic/prf_top.sv ====
// banked physical register file
`default_nettype none

module prf_top #(
    parameter int RR_COUNT = 6,
    parameter int WR_COUNT = 3
) (
    input  wire                                                 CLK,
    input  wire                                                 nRST,

    // writeback
    input  wire logic [WR_COUNT-1:0]                            wb_valid,
    input  wire prf_pkg::wb_req_t [WR_COUNT-1:0]                wb_req,
    output logic [WR_COUNT-1:0]                                 wb_ready,
    output prf_pkg::wb_bus_t [prf_pkg::BANK_COUNT-1:0]          wb_bus,

    // register reads
    input  wire logic [RR_COUNT-1:0]                            rd_req_valid,
    input  wire prf_pkg::pr_t [RR_COUNT-1:0]                    rd_req_pr,
    output logic [RR_COUNT-1:0]                                 rd_ack,
    output prf_pkg::rd_port_e [RR_COUNT-1:0]                    rd_port,
    output wire prf_pkg::data_t [prf_pkg::BANK_COUNT-1:0][1:0]  rd_data
);

    import prf_pkg::*;

    upper_pr_t [BANK_COUNT-1:0] rd_row0;
    upper_pr_t [BANK_COUNT-1:0] rd_row1;

    wb_arbiter #(.WR_COUNT(WR_COUNT)) u_wb_arbiter (
        .CLK      (CLK),
        .nRST     (nRST),
        .wb_valid (wb_valid),
        .wb_req   (wb_req),
        .wb_ready (wb_ready),
        .wb_bus   (wb_bus)
    );

    read_arbiter #(.RR_COUNT(RR_COUNT)) u_read_arbiter (
        .CLK          (CLK),
        .nRST         (nRST),
        .rd_req_valid (rd_req_valid),
        .rd_req_pr    (rd_req_pr),
        .rd_ack       (rd_ack),
        .rd_port      (rd_port),
        .rd_row0      (rd_row0),
        .rd_row1      (rd_row1)
    );

    // each bank is written straight from its own bus entry
    for (genvar b = 0; b < BANK_COUNT; b++) begin : g_bank
        bank_ram u_bank_ram (
            .CLK      (CLK),
            .wr_en    (wb_bus[b].valid),
            .wr_row   (wb_bus[b].upper_pr),
            .wr_data  (wb_bus[b].data),
            .rd_row0  (rd_row0[b]),
            .rd_row1  (rd_row1[b]),
            .rd_data0 (rd_data[b][0]),
            .rd_data1 (rd_data[b][1])
        );
    end

endmodule

`default_nettype wire

// ==== logic/read_arbiter.sv ====
// read arbiter, two ports per bank
`default_nettype none

module read_arbiter #(
    parameter int RR_COUNT = 6
) (
    input  wire                                             CLK,
    input  wire                                             nRST,

    // requester side
    input  wire logic [RR_COUNT-1:0]                        rd_req_valid,
    input  wire prf_pkg::pr_t [RR_COUNT-1:0]                rd_req_pr,
    output logic [RR_COUNT-1:0]                             rd_ack,
    output prf_pkg::rd_port_e [RR_COUNT-1:0]                rd_port,

    // registered row indices per bank and port
    output prf_pkg::upper_pr_t [prf_pkg::BANK_COUNT-1:0]    rd_row0,
    output prf_pkg::upper_pr_t [prf_pkg::BANK_COUNT-1:0]    rd_row1
);

    import prf_pkg::*;

    // requests still waiting for an ack
    logic [RR_COUNT-1:0]                    pend_valid;
    pr_t [RR_COUNT-1:0]                     pend_pr;

    logic [RR_COUNT-1:0]                    cand_valid;
    pr_t [RR_COUNT-1:0]                     cand_pr;
    logic [BANK_COUNT-1:0][RR_COUNT-1:0]    cand_by_bank;

    logic [BANK_COUNT-1:0][RR_COUNT-1:0]    grant0;
    logic [BANK_COUNT-1:0][RR_COUNT-1:0]    grant1;
    logic [BANK_COUNT-1:0][RR_COUNT-1:0]    mask_q;
    logic [BANK_COUNT-1:0][RR_COUNT-1:0]    next_mask;

    logic [RR_COUNT-1:0]                    next_ack;
    rd_port_e [RR_COUNT-1:0]                next_port;
    upper_pr_t [BANK_COUNT-1:0]             next_row0;
    upper_pr_t [BANK_COUNT-1:0]             next_row1;

    // ------------------------------
    // candidates and bank demux

    always_comb begin
        for (int r = 0; r < RR_COUNT; r++) begin
            cand_valid[r] = pend_valid[r] | rd_req_valid[r];
            cand_pr[r] = pend_valid[r] ? pend_pr[r] : rd_req_pr[r];
        end

        cand_by_bank = '0;
        for (int r = 0; r < RR_COUNT; r++) begin
            cand_by_bank[cand_pr[r][LOG_BANK_COUNT-1:0]][r] = cand_valid[r];
        end
    end

    for (genvar b = 0; b < BANK_COUNT; b++) begin : g_bank
        rotating_pick #(
            .WIDTH (RR_COUNT)
        ) u_pick0 (
            .req   (cand_by_bank[b]),
            .mask  (mask_q[b]),
            .grant (grant0[b])
        );

        // port 1 sees what port 0 left over
        rotating_pick #(
            .WIDTH (RR_COUNT)
        ) u_pick1 (
            .req   (cand_by_bank[b] & ~grant0[b]),
            .mask  (mask_q[b]),
            .grant (grant1[b])
        );

        // the two ports of a bank never serve the same requester
        a_two_grants: assert property (@(posedge CLK) disable iff (!nRST)
            $onehot0(grant0[b]) && $onehot0(grant1[b]) && (grant0[b] & grant1[b]) == '0);
    end

    // ------------------------------
    // acks, ports, rows, rotation

    always_comb begin
        next_ack = '0;
        for (int r = 0; r < RR_COUNT; r++) begin
            next_port[r] = RD_PORT0;
        end

        for (int b = 0; b < BANK_COUNT; b++) begin
            next_ack |= grant0[b] | grant1[b];
            next_row0[b] = '0;
            next_row1[b] = '0;
            for (int r = 0; r < RR_COUNT; r++) begin
                if (grant1[b][r]) begin
                    next_port[r] = RD_PORT1;
                end
                next_row0[b] |= cand_pr[r][LOG_PR_COUNT-1:LOG_BANK_COUNT]
                    & {UPPER_PR_WIDTH{grant0[b][r]}};
                next_row1[b] |= cand_pr[r][LOG_PR_COUNT-1:LOG_BANK_COUNT]
                    & {UPPER_PR_WIDTH{grant1[b][r]}};
            end

            // mask follows port 1, cleared when port 1 is unused
            next_mask[b] = '0;
            for (int r = 1; r < RR_COUNT; r++) begin
                next_mask[b][r] = next_mask[b][r-1] | grant1[b][r-1];
            end
        end
    end

    // ------------------------------
    // registers

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            pend_valid <= '0;
            mask_q <= '0;
            rd_ack <= '0;
            for (int r = 0; r < RR_COUNT; r++) begin
                rd_port[r] <= RD_PORT0;
            end
        end else begin
            pend_valid <= cand_valid & ~next_ack;
            mask_q <= next_mask;
            rd_ack <= next_ack;
            rd_port <= next_port;
        end
    end

    always_ff @(posedge CLK) begin
        pend_pr <= cand_pr;
        rd_row0 <= next_row0;
        rd_row1 <= next_row1;
    end

endmodule

`default_nettype wire

// ==== logic/wb_arbiter.sv ====
// writeback arbiter and bus registers
`default_nettype none

module wb_arbiter #(
    parameter int WR_COUNT = 3
) (
    input  wire                                         CLK,
    input  wire                                         nRST,

    // writer handshake
    input  wire logic [WR_COUNT-1:0]                    wb_valid,
    input  wire prf_pkg::wb_req_t [WR_COUNT-1:0]        wb_req,
    output logic [WR_COUNT-1:0]                         wb_ready,

    // registered writeback bus per bank
    output prf_pkg::wb_bus_t [prf_pkg::BANK_COUNT-1:0]  wb_bus
);

    import prf_pkg::*;

    // holding slot per writer
    logic [WR_COUNT-1:0]                    slot_valid;
    wb_req_t [WR_COUNT-1:0]                 slot_req;

    // slot contents merged with fresh requests
    logic [WR_COUNT-1:0]                    cand_valid;
    wb_req_t [WR_COUNT-1:0]                 cand_req;

    logic [BANK_COUNT-1:0][WR_COUNT-1:0]    cand_by_bank;
    logic [BANK_COUNT-1:0][WR_COUNT-1:0]    grant_by_bank;
    logic [WR_COUNT-1:0]                    granted;

    logic [BANK_COUNT-1:0][WR_COUNT-1:0]    mask_q;
    logic [BANK_COUNT-1:0][WR_COUNT-1:0]    next_mask;
    wb_bus_t [BANK_COUNT-1:0]               next_bus;

    // a full slot stalls its writer
    assign wb_ready = ~slot_valid;

    // ------------------------------
    // candidates and bank demux

    always_comb begin
        for (int w = 0; w < WR_COUNT; w++) begin
            // a presented request is ignored while the slot is full
            cand_valid[w] = slot_valid[w] | wb_valid[w];
            cand_req[w] = slot_valid[w] ? slot_req[w] : wb_req[w];
        end

        cand_by_bank = '0;
        for (int w = 0; w < WR_COUNT; w++) begin
            cand_by_bank[cand_req[w].pr[LOG_BANK_COUNT-1:0]][w] = cand_valid[w];
        end
    end

    for (genvar b = 0; b < BANK_COUNT; b++) begin : g_bank
        rotating_pick #(
            .WIDTH (WR_COUNT)
        ) u_pick (
            .req   (cand_by_bank[b]),
            .mask  (mask_q[b]),
            .grant (grant_by_bank[b])
        );
    end

    // ------------------------------
    // bus mux and rotation

    always_comb begin
        granted = '0;
        for (int b = 0; b < BANK_COUNT; b++) begin
            granted |= grant_by_bank[b];

            // one-hot AND-OR mux of the granted writer
            next_bus[b] = '0;
            next_bus[b].valid = |grant_by_bank[b];
            for (int w = 0; w < WR_COUNT; w++) begin
                next_bus[b].data |= cand_req[w].data & {DATA_WIDTH{grant_by_bank[b][w]}};
                next_bus[b].upper_pr |= cand_req[w].pr[LOG_PR_COUNT-1:LOG_BANK_COUNT]
                    & {UPPER_PR_WIDTH{grant_by_bank[b][w]}};
                next_bus[b].rob_index |= cand_req[w].rob_index
                    & {ROB_INDEX_WIDTH{grant_by_bank[b][w]}};
            end

            // register 0 is bank 0 row 0, never written or advertised
            if (b == 0 && next_bus[b].upper_pr == '0) begin
                next_bus[b].valid = 1'b0;
            end

            // rotate past this cycle's grantee, keep the mask while idle
            next_mask[b] = mask_q[b];
            if (|grant_by_bank[b]) begin
                next_mask[b] = '0;
                for (int w = 1; w < WR_COUNT; w++) begin
                    next_mask[b][w] = next_mask[b][w-1] | grant_by_bank[b][w-1];
                end
            end
        end
    end

    // ------------------------------
    // registers

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            slot_valid <= '0;
            mask_q <= '0;
            wb_bus <= '0;
        end else begin
            slot_valid <= cand_valid & ~granted;
            mask_q <= next_mask;
            wb_bus <= next_bus;
        end
    end

    always_ff @(posedge CLK) begin
        slot_req <= cand_req;
    end

    a_no_pr0_bus: assert property (@(posedge CLK) disable iff (!nRST)
        !(wb_bus[0].valid && wb_bus[0].upper_pr == '0));

    // a writer stalls only behind a request it presented earlier
    for (genvar w = 0; w < WR_COUNT; w++) begin : g_ready_chk
        a_ready_low: assert property (@(posedge CLK) disable iff (!nRST)
            !wb_ready[w] |-> $past(wb_valid[w] || !wb_ready[w]));
    end

endmodule

`default_nettype wire

// ==== logic/bank_ram.sv ====
// register bank storage
`default_nettype none

module bank_ram (
    input  wire                     CLK,

    // write port, fed by the bank's writeback bus
    input  wire logic               wr_en,
    input  wire prf_pkg::upper_pr_t wr_row,
    input  wire prf_pkg::data_t     wr_data,

    // two read ports with registered row indices
    input  wire prf_pkg::upper_pr_t rd_row0,
    input  wire prf_pkg::upper_pr_t rd_row1,
    output prf_pkg::data_t          rd_data0,
    output prf_pkg::data_t          rd_data1
);

    import prf_pkg::*;

    localparam int ROWS = PR_COUNT / BANK_COUNT;

    data_t rows [ROWS];

    // ------------------------------
    // write

    always_ff @(posedge CLK) begin
        if (wr_en) begin
            rows[wr_row] <= wr_data;
        end
    end

    // ------------------------------
    // asynchronous read

    assign rd_data0 = rows[rd_row0];
    assign rd_data1 = rows[rd_row1];

    // a bus entry that writes must carry a known row
    a_wr_row_known: assert property (@(posedge CLK) wr_en |-> !$isunknown(wr_row));

endmodule

`default_nettype wire

// ==== logic/rotating_pick.sv ====
// rotating priority picker
`default_nettype none

module rotating_pick #(
    parameter int WIDTH = 4
) (
    input  wire logic [WIDTH-1:0] req,
    input  wire logic [WIDTH-1:0] mask,
    output logic [WIDTH-1:0]      grant
);

    logic [WIDTH-1:0] masked_req;
    logic [WIDTH-1:0] masked_grant;
    logic [WIDTH-1:0] plain_grant;

    // lowest set bit of a vector, zero when empty
    function automatic logic [WIDTH-1:0] lowest(input logic [WIDTH-1:0] vec);
        logic [WIDTH-1:0] pick;
        pick = '0;
        for (int i = WIDTH - 1; i >= 0; i--) begin
            if (vec[i]) begin
                pick = '0;
                pick[i] = 1'b1;
            end
        end
        return pick;
    endfunction

    // requesters above the last grantee
    assign masked_req = req & mask;

    assign masked_grant = lowest(masked_req);
    assign plain_grant = lowest(req);

    // wrap around to the bottom once nobody above is waiting
    assign grant = (|masked_req) ? masked_grant : plain_grant;

endmodule

`default_nettype wire

// ==== logic/prf_pkg.sv ====
// physical register file types
`default_nettype none

package prf_pkg;

    // ------------------------------
    // sizes

    parameter int DATA_WIDTH = 32;

    parameter int PR_COUNT = 64;
    parameter int LOG_PR_COUNT = 6;

    parameter int BANK_COUNT = 4;
    parameter int LOG_BANK_COUNT = 2;

    // row index inside one bank
    parameter int UPPER_PR_WIDTH = LOG_PR_COUNT - LOG_BANK_COUNT;

    parameter int ROB_INDEX_WIDTH = 5;

    // ------------------------------
    // types

    typedef logic [DATA_WIDTH-1:0] data_t;
    // low bits pick the bank, high bits the row
    typedef logic [LOG_PR_COUNT-1:0] pr_t;
    typedef logic [UPPER_PR_WIDTH-1:0] upper_pr_t;
    typedef logic [ROB_INDEX_WIDTH-1:0] rob_index_t;

    // one writer's writeback request
    typedef struct packed {
        data_t      data;
        pr_t        pr;
        rob_index_t rob_index;
    } wb_req_t;

    // one bank's writeback bus entry
    typedef struct packed {
        logic       valid;
        data_t      data;
        upper_pr_t  upper_pr;
        rob_index_t rob_index;
    } wb_bus_t;

    // read port that served a request
    typedef enum logic {
        RD_PORT0,
        RD_PORT1
    } rd_port_e;

endpackage

`default_nettype wire
